// ==== src/nrf_pkg.sv ====
`default_nettype none

package nrf_pkg;

  typedef logic [7:0] byte_t;  // one spi byte

  ////////////////////////////////////////
  // timing, clk cycles at 50 MHz
  localparam int SCK_HALF_CYCLES = 25;      // 1 MHz sck
  localparam int POWER_ON_CYCLES = 600000;  // 12 ms
  localparam int STANDBY_CYCLES  = 100000;  // 2 ms after ce rises
  localparam int CS_GAP_CYCLES   = 100;     // csn high between transactions
  localparam int POLL_GAP_CYCLES = 25000;   // 500 us between payload reads
  localparam int TICK_W          = $clog2(SCK_HALF_CYCLES);
  localparam int DELAY_W         = $clog2(POWER_ON_CYCLES);  // longest wait sets the width

  localparam byte_t RX_DATA_RESET = 8'h7E;

  ////////////////////////////////////////
  // nrf24l01 commands and register map
  localparam byte_t CMD_W_REGISTER   = 8'h20;  // 001a_aaaa
  localparam byte_t CMD_R_RX_PAYLOAD = 8'h61;
  localparam byte_t CMD_FLUSH_RX     = 8'hE2;
  localparam byte_t CMD_NOP          = 8'hFF;

  localparam logic [4:0] REG_CONFIG     = 5'h00;
  localparam logic [4:0] REG_EN_AA      = 5'h01;
  localparam logic [4:0] REG_EN_RXADDR  = 5'h02;
  localparam logic [4:0] REG_SETUP_AW   = 5'h03;
  localparam logic [4:0] REG_SETUP_RETR = 5'h04;
  localparam logic [4:0] REG_RF_CH      = 5'h05;
  localparam logic [4:0] REG_RF_SETUP   = 5'h06;
  localparam logic [4:0] REG_STATUS     = 5'h07;
  localparam logic [4:0] REG_RX_ADDR_P0 = 5'h0A;
  localparam logic [4:0] REG_RX_PW_P0   = 5'h11;

  localparam byte_t CONFIG_VALUE     = 8'h1F;  // crc 2 bytes, pwr_up, prim_rx
  localparam byte_t EN_AA_VALUE      = 8'h00;  // no auto ack
  localparam byte_t EN_RXADDR_VALUE  = 8'h01;  // pipe 0 only
  localparam byte_t SETUP_AW_VALUE   = 8'h03;  // 5 byte address
  localparam byte_t RF_CH_VALUE      = 8'h01;  // 2.401 GHz
  localparam byte_t RF_SETUP_VALUE   = 8'h07;  // 1 Mbps, 0 dBm
  localparam byte_t SETUP_RETR_VALUE = 8'h00;
  localparam byte_t STATUS_CLEAR     = 8'h40;  // clears rx_dr
  localparam byte_t RX_PW_P0_VALUE   = 8'h01;  // 1 byte payload
  localparam byte_t RX_ADDR_BYTE     = 8'hED;
  localparam int    RX_ADDR_BYTES    = 5;

  ////////////////////////////////////////
  // rom step layout and ctrl states
  localparam int STEP_W      = 5;
  localparam int ADDR_STEP   = 16;                             // after eight write pairs
  localparam int FLUSH_STEP  = ADDR_STEP + 1 + RX_ADDR_BYTES;
  localparam int STATUS_STEP = FLUSH_STEP + 1;
  localparam int CFG_STEPS   = STATUS_STEP + 3;                // status pair, then start_rx marker

  localparam logic [2:0] ST_POWER_ON = 3'd0;
  localparam logic [2:0] ST_LOAD     = 3'd1;
  localparam logic [2:0] ST_SHIFT    = 3'd2;
  localparam logic [2:0] ST_GAP      = 3'd3;
  localparam logic [2:0] ST_STANDBY  = 3'd4;

  typedef union packed {
    byte_t raw;           // opcode as sent
    struct packed {
      logic [2:0] prefix; // 001 for w_register
      logic [4:0] addr;
    } reg_access;
  } spi_cmd_u;

  typedef enum logic [1:0] {
    SEND,     // shift, drop the reply
    CAPTURE,  // shift, keep the reply
    START_RX  // raise ce, enter polling
  } step_kind_e;

endpackage

`default_nettype wire

// ==== src/spi_byte_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface spi_byte_if import nrf_pkg::*; ();

  logic  start;    // one cycle pulse from ctrl
  byte_t tx_byte;  // held by ctrl while busy
  logic  busy;     // byte in flight
  logic  done;     // one cycle pulse, rx_byte valid
  byte_t rx_byte;  // byte shifted in from miso

  modport ctrl (
    output start,
    output tx_byte,
    input  busy,
    input  done,
    input  rx_byte
  );

  modport shifter (
    input  start,
    input  tx_byte,
    output busy,
    output done,
    output rx_byte
  );

endinterface

`default_nettype wire

// ==== src/nrf_cmd_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module nrf_cmd_rom import nrf_pkg::*; (
  input  wire logic [STEP_W-1:0] step,
  output byte_t                  step_byte,
  output logic                   step_last,
  output step_kind_e             step_kind
);

  // w_register opcode, address dropped into the register view
  function automatic byte_t w_reg(input logic [4:0] addr);
    spi_cmd_u cmd;
    cmd.raw = CMD_W_REGISTER;
    cmd.reg_access.addr = addr;
    return cmd.raw;
  endfunction

  always_comb begin
    step_byte = CMD_NOP;  // nop also fills the capture step
    case (step) inside
      5'd0:  step_byte = w_reg(REG_CONFIG);
      5'd1:  step_byte = CONFIG_VALUE;
      5'd2:  step_byte = w_reg(REG_EN_AA);
      5'd3:  step_byte = EN_AA_VALUE;
      5'd4:  step_byte = w_reg(REG_EN_RXADDR);
      5'd5:  step_byte = EN_RXADDR_VALUE;
      5'd6:  step_byte = w_reg(REG_SETUP_AW);
      5'd7:  step_byte = SETUP_AW_VALUE;
      5'd8:  step_byte = w_reg(REG_RF_CH);
      5'd9:  step_byte = RF_CH_VALUE;
      5'd10: step_byte = w_reg(REG_RF_SETUP);
      5'd11: step_byte = RF_SETUP_VALUE;
      5'd12: step_byte = w_reg(REG_SETUP_RETR);
      5'd13: step_byte = SETUP_RETR_VALUE;
      5'd14: step_byte = w_reg(REG_RX_PW_P0);
      5'd15: step_byte = RX_PW_P0_VALUE;
      ADDR_STEP: step_byte = w_reg(REG_RX_ADDR_P0);
      [ADDR_STEP+1:ADDR_STEP+RX_ADDR_BYTES]: step_byte = RX_ADDR_BYTE;  // pipe 0 address, 5x ED
      FLUSH_STEP: step_byte = CMD_FLUSH_RX;
      STATUS_STEP: step_byte = w_reg(REG_STATUS);
      STATUS_STEP+1: step_byte = STATUS_CLEAR;
      CFG_STEPS: step_byte = CMD_R_RX_PAYLOAD;  // first polling step
      default: step_byte = CMD_NOP;
    endcase
  end

  always_comb begin
    case (step) inside
      [0:ADDR_STEP-1]: step_last = step[0];  // value byte closes each write pair
      ADDR_STEP+RX_ADDR_BYTES, FLUSH_STEP, STATUS_STEP+1, CFG_STEPS+1: step_last = 1'b1;
      default: step_last = 1'b0;
    endcase
  end

  always_comb begin
    case (step) inside
      CFG_STEPS-1: step_kind = START_RX;
      CFG_STEPS+1: step_kind = CAPTURE;    // reply to the nop is the payload
      default:     step_kind = SEND;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/spi_byte_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_byte_shifter import nrf_pkg::*; (
  input  wire logic   clk,
  input  wire logic   reset,
  spi_byte_if.shifter byte_port,
  input  wire logic   miso,
  output logic        sck,
  output logic        mosi
);

  logic [TICK_W-1:0] tick_cnt;  // clk cycles inside one sck half
  logic [3:0]        half_cnt;  // 16 halves per byte
  logic              half_end;
  byte_t             tx_shift;  // bit 7 is on mosi
  byte_t             rx_shift;

  assign half_end = byte_port.busy && (tick_cnt == TICK_W'(SCK_HALF_CYCLES - 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      byte_port.busy <= 1'b0;
      byte_port.done <= 1'b0;
      tick_cnt       <= '0;
      half_cnt       <= '0;
      sck            <= 1'b0;
      mosi           <= 1'b0;
    end else begin
      byte_port.done <= 1'b0;
      if (!byte_port.busy) begin
        if (byte_port.start) begin
          byte_port.busy <= 1'b1;
          tick_cnt       <= TICK_W'(1);  // start cycle counts toward the first half
          half_cnt       <= '0;
          mosi           <= byte_port.tx_byte[7];  // msb set up ahead of first rise
        end
      end else if (half_end) begin
        tick_cnt <= '0;
        half_cnt <= half_cnt + 1'b1;
        sck      <= ~half_cnt[0];  // even halves end on a rise, odd on a fall
        if (half_cnt[0]) begin
          if (half_cnt == 4'd15) begin
            byte_port.busy <= 1'b0;
            byte_port.done <= 1'b1;
            mosi           <= 1'b0;  // rest low
          end else begin
            mosi <= tx_shift[6];  // next bit, sck going low
          end
        end
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!byte_port.busy && byte_port.start) begin
      tx_shift <= byte_port.tx_byte;
    end else if (half_end && half_cnt[0]) begin
      tx_shift <= {tx_shift[6:0], 1'b0};  // msb first
    end
    if (half_end && !half_cnt[0]) begin
      rx_shift <= {rx_shift[6:0], miso};  // sample on sck rise
    end
    if (half_end && half_cnt == 4'd15) begin
      byte_port.rx_byte <= rx_shift;  // all 8 rises taken
    end
  end

endmodule

`default_nettype wire

// ==== src/nrf_rx_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module nrf_rx_ctrl import nrf_pkg::*; (
  input  wire logic         clk,
  input  wire logic         reset,
  spi_byte_if.ctrl          byte_port,
  output logic [STEP_W-1:0] step,
  input  wire byte_t        step_byte,
  input  wire logic         step_last,
  input  wire step_kind_e   step_kind,
  output logic              csn,
  output logic              ce,
  output byte_t             rx_data,
  output logic              payload_valid
);

  logic [2:0]         state;
  logic [DELAY_W-1:0] delay_cnt;   // shared by every wait
  logic               delay_done;
  logic               poll_end;    // current step is the capture nop
  logic               can_start;

  assign delay_done = (delay_cnt == '0);
  assign poll_end   = (step == STEP_W'(CFG_STEPS + 1));
  assign can_start  = (state == ST_LOAD) && (step_kind != START_RX) && !byte_port.busy;

  ////////////////////////////////////////
  // sequencing fsm
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state           <= ST_POWER_ON;
      delay_cnt       <= DELAY_W'(POWER_ON_CYCLES - 1);
      step            <= '0;
      csn             <= 1'b1;
      ce              <= 1'b0;
      byte_port.start <= 1'b0;
      rx_data         <= RX_DATA_RESET;
      payload_valid   <= 1'b0;
    end else begin
      byte_port.start <= 1'b0;  // pulses
      payload_valid   <= 1'b0;
      case (state)
        ST_POWER_ON, ST_GAP, ST_STANDBY: begin
          if (delay_done) begin
            state <= ST_LOAD;
          end else begin
            delay_cnt <= delay_cnt - 1'b1;
          end
        end

        ST_LOAD: begin
          if (step_kind == START_RX) begin
            ce        <= 1'b1;  // rx mode from here on
            step      <= step + 1'b1;
            delay_cnt <= DELAY_W'(STANDBY_CYCLES - 2);  // ST_LOAD adds one cycle
            state     <= ST_STANDBY;
          end else if (can_start) begin
            csn             <= 1'b0;  // no-op inside a transaction
            byte_port.start <= 1'b1;
            state           <= ST_SHIFT;
          end
        end

        ST_SHIFT: begin
          if (byte_port.done) begin
            if (step_kind == CAPTURE) begin
              rx_data       <= byte_port.rx_byte;
              payload_valid <= 1'b1;
            end
            // polling pair repeats forever
            step <= poll_end ? STEP_W'(CFG_STEPS) : step + 1'b1;
            if (step_last) begin
              csn   <= 1'b1;  // end of transaction
              state <= ST_GAP;
              if (poll_end) begin
                delay_cnt <= DELAY_W'(POLL_GAP_CYCLES - 2);
              end else begin
                delay_cnt <= DELAY_W'(CS_GAP_CYCLES - 2);  // csn high for CS_GAP_CYCLES
              end
            end else begin
              state <= ST_LOAD;  // next byte, csn stays low
            end
          end
        end

        default: state <= ST_POWER_ON;
      endcase
    end
  end

  // tx byte only changes as a start goes out
  always_ff @(posedge clk) begin
    if (can_start) begin
      byte_port.tx_byte <= step_byte;
    end
  end

endmodule

`default_nettype wire

// ==== src/nrf_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module nrf_rx_top import nrf_pkg::*; (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic miso,
  output logic      sck,
  output logic      csn,
  output logic      ce,
  output logic      mosi,
  output byte_t     rx_data,
  output logic      payload_valid
);

  spi_byte_if byte_bus ();  // ctrl to shifter

  logic [STEP_W-1:0] step;
  byte_t             step_byte;
  logic              step_last;
  step_kind_e        step_kind;

  nrf_rx_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .byte_port     (byte_bus.ctrl),
    .step          (step),
    .step_byte     (step_byte),
    .step_last     (step_last),
    .step_kind     (step_kind),
    .csn           (csn),
    .ce            (ce),
    .rx_data       (rx_data),
    .payload_valid (payload_valid)
  );

  nrf_cmd_rom u_rom (
    .step      (step),
    .step_byte (step_byte),
    .step_last (step_last),
    .step_kind (step_kind)
  );

  spi_byte_shifter u_shifter (
    .clk       (clk),
    .reset     (reset),
    .byte_port (byte_bus.shifter),
    .miso      (miso),
    .sck       (sck),
    .mosi      (mosi)
  );

endmodule

`default_nettype wire

// ==== tb/nrf_spi_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module nrf_spi_model import nrf_pkg::*; (
  input  wire logic  clk,
  input  wire logic  csn,
  input  wire logic  sck,
  input  wire logic  mosi,
  output logic       miso,
  input  wire byte_t payload,          // reply byte for a payload read
  output byte_t      txn_data [8],     // bytes of the last closed transaction
  output int         txn_len,
  output int         txn_count,        // closed transactions so far
  output int         write_count       // w_register commands seen
);

  logic     sck_q;
  logic     csn_q;
  int       bit_cnt;     // bits of the current byte
  int       cur_len;     // bytes of the open transaction
  logic     in_read;     // first byte was r_rx_payload
  byte_t    rx_shift;
  byte_t    tx_shift;
  byte_t    cur_bytes [8];
  spi_cmd_u first_cmd;

  initial begin
    sck_q    = 1'b0;
    csn_q    = 1'b1;
    bit_cnt  = 0;
    cur_len  = 0;
    in_read  = 1'b0;
    rx_shift = 8'h00;
    tx_shift = 8'h00;
    for (int i = 0; i < 8; i++) begin
      cur_bytes[i]  = 8'h00;
      txn_data[i]  <= 8'h00;
    end
    miso        <= 1'b0;
    txn_len     <= 0;
    txn_count   <= 0;
    write_count <= 0;
  end

  // pins sampled on the falling clk edge, away from dut updates
  always @(negedge clk) begin
    if (csn_q && !csn) begin  // transaction opens
      cur_len  = 0;
      bit_cnt  = 0;
      in_read  = 1'b0;
      tx_shift = 8'h00;
      miso    <= 1'b0;
    end
    if (!csn && sck && !sck_q) begin  // sck rise, take mosi
      rx_shift = {rx_shift[6:0], mosi};
      bit_cnt  = bit_cnt + 1;
      if (bit_cnt == 8) begin
        bit_cnt = 0;
        if (cur_len == 0) begin
          first_cmd.raw = rx_shift;
          in_read       = (first_cmd.raw == CMD_R_RX_PAYLOAD);  // opcode view
          if (first_cmd.reg_access.prefix == 3'b001) begin      // register view
            write_count <= write_count + 1;
          end
        end
        if (cur_len < 8) begin
          cur_bytes[cur_len[2:0]] = rx_shift;
        end
        cur_len = cur_len + 1;
      end
    end
    if (!csn && !sck && sck_q) begin  // sck fall, next miso bit
      if (bit_cnt == 0) begin
        tx_shift = in_read ? payload : 8'h00;  // byte boundary
      end else begin
        tx_shift = {tx_shift[6:0], 1'b0};
      end
      miso <= tx_shift[7];
    end
    if (!csn_q && csn) begin  // transaction closes
      txn_data  <= cur_bytes;
      txn_len   <= cur_len;
      txn_count <= txn_count + 1;
    end
    sck_q = sck;
    csn_q = csn;
  end

endmodule

`default_nettype wire

// ==== tb/nrf_rx_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module nrf_rx_checker (
  input wire logic clk,
  input wire logic reset,
  input wire logic sck,
  input wire logic csn,
  input wire logic mosi,
  input wire logic ce,
  input wire logic payload_valid
);

  logic csn_fell;  // first chip select seen

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      csn_fell <= 1'b0;
    end else if (!csn) begin
      csn_fell <= 1'b1;
    end
  end

  sck_idle_a: assert property (@(posedge clk) disable iff (reset) csn |-> !sck)
    else $error("sck high while csn is high");

  mosi_hold_a: assert property (@(posedge clk) disable iff (reset)
    (sck && $past(sck)) |-> $stable(mosi))
    else $error("mosi moved while sck was high");

  valid_rx_a: assert property (@(posedge clk) disable iff (reset) payload_valid |-> ce)
    else $error("payload_valid pulsed with ce low");

  ce_late_a: assert property (@(posedge clk) disable iff (reset) !csn_fell |-> !ce)
    else $error("ce raised before the first csn fall");

endmodule

bind nrf_rx_top nrf_rx_checker u_checker (
  .clk           (clk),
  .reset         (reset),
  .sck           (sck),
  .csn           (csn),
  .mosi          (mosi),
  .ce            (ce),
  .payload_valid (payload_valid)
);

`default_nettype wire

// ==== tb/nrf_rx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module nrf_rx_tb import nrf_pkg::*; ();

  localparam int BYTE_CYCLES = 16 * SCK_HALF_CYCLES;  // clk cycles per spi byte
  localparam int POLLS       = 8;

  logic  clk;
  logic  reset;
  logic  miso;
  logic  sck;
  logic  csn;
  logic  ce;
  logic  mosi;
  byte_t rx_data;
  logic  payload_valid;
  byte_t payload;        // radio reply for the next read
  byte_t txn_data [8];
  int    txn_len;
  int    txn_count;
  int    write_count;

  byte_t payload_q [$];
  byte_t exp_bytes [$];  // expected config bytes, all transactions back to back
  int    exp_lens [$];
  int    seen_txns;

  nrf_rx_top dut (
    .clk           (clk),
    .reset         (reset),
    .miso          (miso),
    .sck           (sck),
    .csn           (csn),
    .ce            (ce),
    .mosi          (mosi),
    .rx_data       (rx_data),
    .payload_valid (payload_valid)
  );

  nrf_spi_model radio (
    .clk         (clk),
    .csn         (csn),
    .sck         (sck),
    .mosi        (mosi),
    .miso        (miso),
    .payload     (payload),
    .txn_data    (txn_data),
    .txn_len     (txn_len),
    .txn_count   (txn_count),
    .write_count (write_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 100 MHz sim clock, 50 MHz timing constants
  end

  ////////////////////////////////////////
  // reporting
  task automatic end_with_failure();
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %02h actual %02h", name, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %b actual %b", name, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
      end_with_failure();
    end
  endtask

  ////////////////////////////////////////
  // waits, each with its own limit
  task automatic wait_txn(input string name, input int limit, input logic ce_low);
    int cycles;
    cycles = 0;
    while (txn_count == seen_txns) begin
      @(negedge clk);
      if (ce_low) begin
        check_bit({name, " ce low"}, 1'b0, ce);  // no rx mode during config
      end
      cycles = cycles + 1;
      if (cycles > limit) begin
        $display("timeout, no spi transaction closed during %s", name);
        end_with_failure();
      end
    end
    seen_txns = seen_txns + 1;
  endtask

  task automatic wait_csn_low(input string name, input int limit);
    int cycles;
    cycles = 0;
    while (csn) begin
      @(negedge clk);
      cycles = cycles + 1;
      if (cycles > limit) begin
        $display("timeout, csn never went low before %s", name);
        end_with_failure();
      end
    end
  endtask

  task automatic wait_valid(input string name, input int limit);
    int cycles;
    cycles = 0;
    while (!payload_valid) begin
      @(negedge clk);
      cycles = cycles + 1;
      if (cycles > limit) begin
        $display("timeout, payload_valid never pulsed in %s", name);
        end_with_failure();
      end
    end
  endtask

  task automatic compare_txn(input string name, input int offset, input int len);
    check_count({name, " length"}, len, txn_len);
    for (int i = 0; i < len; i++) begin
      check_byte(name, exp_bytes[offset + i], txn_data[i[2:0]]);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  initial begin
    int limit;
    int offset;
    reset     = 1'b1;
    payload   = 8'h00;
    seen_txns = 0;
    offset    = 0;
    void'($urandom(32'h998e2685));
    for (int i = 0; i < POLLS; i++) begin
      payload_q.push_back(byte_t'($urandom));
    end
    payload = payload_q[0];

    // write command is 20 | register address, then the value
    exp_bytes = '{8'h20, 8'h1F, 8'h21, 8'h00, 8'h22, 8'h01, 8'h23, 8'h03,
                  8'h25, 8'h01, 8'h26, 8'h07, 8'h24, 8'h00, 8'h31, 8'h01,
                  8'h2A, 8'hED, 8'hED, 8'hED, 8'hED, 8'hED,
                  8'hE2,
                  8'h27, 8'h40};
    exp_lens  = '{2, 2, 2, 2, 2, 2, 2, 2, 6, 1, 2};

    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_bit("reset csn", 1'b1, csn);
    check_bit("reset ce", 1'b0, ce);
    check_bit("reset sck", 1'b0, sck);
    check_bit("reset mosi", 1'b0, mosi);
    check_bit("reset payload_valid", 1'b0, payload_valid);
    check_byte("reset rx_data", 8'h7E, rx_data);

    // configuration writes, power-on delay before the first
    for (int t = 0; t < exp_lens.size(); t++) begin
      if (t == 0) begin
        limit = 2 * (POWER_ON_CYCLES + 8 * BYTE_CYCLES);
      end else begin
        limit = 2 * (CS_GAP_CYCLES + 8 * BYTE_CYCLES);
      end
      wait_txn("config", limit, 1'b1);
      compare_txn("config transaction", offset, exp_lens[t]);
      offset = offset + exp_lens[t];
    end
    check_count("register writes", 10, write_count);

    wait_csn_low("first poll", 2 * (CS_GAP_CYCLES + STANDBY_CYCLES));
    check_bit("ce before first poll", 1'b1, ce);

    for (int p = 0; p < POLLS; p++) begin
      wait_valid("poll", 2 * (POLL_GAP_CYCLES + 4 * BYTE_CYCLES));
      check_byte("poll payload", payload_q[p], rx_data);
      if (p + 1 < POLLS) begin
        payload = payload_q[p + 1];  // radio answers the next read with this
      end
      @(negedge clk);
      check_bit("payload_valid width", 1'b0, payload_valid);  // one cycle strobe
      wait_txn("poll", 2 * (POLL_GAP_CYCLES + 4 * BYTE_CYCLES), 1'b0);
      check_count("poll length", 2, txn_len);
      check_byte("poll command", 8'h61, txn_data[0]);
      check_byte("poll nop", 8'hFF, txn_data[1]);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
src/nrf_pkg.sv
src/spi_byte_if.sv
src/nrf_cmd_rom.sv
src/spi_byte_shifter.sv
src/nrf_rx_ctrl.sv
src/nrf_rx_top.sv
tb/nrf_spi_model.sv
tb/nrf_rx_checker.sv
tb/nrf_rx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= nrf_rx_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f files.f
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
